// ==== verilog/bicubic_pkg.sv ====
// widths, pixel and channel types, kernel weights and rounding constants
`default_nettype none

package bicubic_pkg;

   localparam int CH_W  = 8;
   localparam int PIX_W = 3 * CH_W;

   typedef logic [CH_W-1:0] chan_t;

   // blue in the high byte, red in the low byte
   typedef struct packed {
      chan_t b;
      chan_t g;
      chan_t r;
   } pixel_t;

   localparam int WIN_N     = 4;   // window side
   localparam int ROW_SLOTS = 4;   // line store depth

   typedef logic signed [19:0] acc_t;   // holds two weighted passes

   localparam int W_OUTER = -1;
   localparam int W_INNER = 9;

   localparam int RND_1D = 8;     // weights sum to 16
   localparam int SH_1D  = 4;
   localparam int RND_2D = 128;   // 16 x 16 after two passes
   localparam int SH_2D  = 8;

endpackage

`default_nettype wire

// ==== verilog/line_store.sv ====
// input row and column counters, four-slot row memory, input ready
`timescale 1ns/1ps
`default_nettype none

module line_store #(
   parameter int IMG_W = 320,
   parameter int IMG_H = 180,
   localparam int CW = $clog2(IMG_W),
   localparam int RW = $clog2(IMG_H + 4)
) (
   input  wire                                                  i_clk,
   input  wire                                                  i_rstn,
   input  bicubic_pkg::pixel_t                                  i_s_data,
   input  wire                                                  i_s_valid,
   output logic                                                 o_s_ready,
   input  wire [CW-1:0]                                         i_rd_col,
   output bicubic_pkg::pixel_t [bicubic_pkg::ROW_SLOTS-1:0]     o_rd_pix,
   input  wire [RW-1:0]                                         i_center_row,
   input  wire                                                  i_frame_done,
   output logic [RW-1:0]                                        o_rows_done
);

   bicubic_pkg::pixel_t mem [bicubic_pkg::ROW_SLOTS][IMG_W];

   logic [CW-1:0] wr_col;
   logic [RW-1:0] wr_row;    // also the count of complete rows
   logic [RW-1:0] row_nxt;
   logic          wr_en;
   logic          row_end;

   assign wr_en       = i_s_valid && o_s_ready;
   assign row_end     = wr_en && (wr_col == CW'(IMG_W - 1));
   assign row_nxt     = i_frame_done ? '0 : (row_end ? wr_row + 1'b1 : wr_row);
   assign o_rows_done = wr_row;

   ////////////////////////////////////////
   // counters and ready
   ////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         wr_col    <= '0;
         wr_row    <= '0;
         o_s_ready <= 1'b0;
      end else begin
         if (row_end)
            wr_col <= '0;
         else if (wr_en)
            wr_col <= wr_col + 1'b1;
         wr_row <= row_nxt;
         // row center+3 would land on the slot of row center-1
         o_s_ready <= (row_nxt < i_center_row + RW'(3)) && (row_nxt < RW'(IMG_H));
      end
   end

   ////////////////////////////////////////
   // row memory
   ////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (wr_en)
         mem[wr_row[1:0]][wr_col] <= i_s_data;   // slot = row mod 4
      for (int k = 0; k < bicubic_pkg::ROW_SLOTS; k++)
         o_rd_pix[k] <= mem[k][i_rd_col];
   end

   // a write never hits a slot the current sweep may still read
   a_wr_safe : assert property (@(posedge i_clk) disable iff (!i_rstn)
      wr_en |-> (wr_row < i_center_row + RW'(3)) && (wr_row < RW'(IMG_H)));

endmodule

`default_nettype wire

// ==== verilog/window_sweeper.sv ====
// sweep control, clamped column reads, 4x4 window assembly, frame done
`timescale 1ns/1ps
`default_nettype none

module window_sweeper #(
   parameter int IMG_W = 320,
   parameter int IMG_H = 180,
   localparam int CW = $clog2(IMG_W),
   localparam int RW = $clog2(IMG_H + 4)
) (
   input  wire                                                  i_clk,
   input  wire                                                  i_rstn,
   input  wire [RW-1:0]                                         i_rows_done,
   input  bicubic_pkg::pixel_t [bicubic_pkg::ROW_SLOTS-1:0]     i_rd_pix,
   input  wire                                                  i_buf_idle,
   output logic [CW-1:0]                                        o_rd_col,
   output logic [RW-1:0]                                        o_center_row,
   output logic                                                 o_frame_done,
   output logic                                                 o_sweep_start,
   output bicubic_pkg::pixel_t [bicubic_pkg::WIN_N-1:0][bicubic_pkg::WIN_N-1:0] o_win,
   output logic                                                 o_win_valid
);

   localparam int CNW = $clog2(IMG_W + 3);

   logic            running;
   logic [CNW-1:0]  cnt;       // read step, column index is cnt-1
   logic [RW-1:0]   need;
   logic            start_ok;
   logic            d_ok;      // data of step 3 or later on i_rd_pix
   logic [1:0]      sel   [bicubic_pkg::WIN_N];
   logic [1:0]      sel_q [bicubic_pkg::WIN_N];
   bicubic_pkg::pixel_t [bicubic_pkg::WIN_N-1:0] col_pix;

   // rows center-1 .. center+2 must be complete, clamped at the bottom
   assign need = (int'(o_center_row) + 3 > IMG_H) ? RW'(IMG_H) : o_center_row + RW'(3);
   assign start_ok = !running && !o_frame_done && i_buf_idle && (i_rows_done >= need);

   ////////////////////////////////////////
   // clamped read indices
   ////////////////////////////////////////
   always_comb begin
      int r;
      for (int k = 0; k < bicubic_pkg::WIN_N; k++) begin
         r = int'(o_center_row) + k - 1;
         if (r < 0)
            r = 0;
         else if (r > IMG_H - 1)
            r = IMG_H - 1;
         sel[k] = 2'(r);   // slot = row mod 4
      end
   end

   always_comb begin
      if (cnt == '0)
         o_rd_col = '0;                  // left edge
      else if (cnt > CNW'(IMG_W))
         o_rd_col = CW'(IMG_W - 1);      // right edge
      else
         o_rd_col = CW'(cnt - 1'b1);
   end

   ////////////////////////////////////////
   // sweep control
   ////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         running       <= 1'b0;
         cnt           <= '0;
         o_center_row  <= '0;
         o_sweep_start <= 1'b0;
         o_frame_done  <= 1'b0;
         d_ok          <= 1'b0;
         o_win_valid   <= 1'b0;
      end else begin
         o_sweep_start <= 1'b0;
         o_frame_done  <= 1'b0;
         d_ok          <= running && (cnt >= CNW'(3));
         o_win_valid   <= d_ok;
         if (!running) begin
            if (start_ok) begin
               running       <= 1'b1;
               cnt           <= '0;
               o_sweep_start <= 1'b1;
            end
         end else if (cnt == CNW'(IMG_W + 2)) begin
            running <= 1'b0;
            if (o_center_row == RW'(IMG_H - 1)) begin
               o_center_row <= '0;
               o_frame_done <= 1'b1;   // last row pair read
            end else begin
               o_center_row <= o_center_row + 1'b1;
            end
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // window shift register
   ////////////////////////////////////////
   // slot choice frozen for the sweep, center moves before the last read returns
   always_ff @(posedge i_clk) begin
      if (start_ok)
         sel_q <= sel;
   end

   always_comb begin
      for (int k = 0; k < bicubic_pkg::WIN_N; k++)
         col_pix[k] = i_rd_pix[sel_q[k]];
   end

   always_ff @(posedge i_clk) begin
      for (int k = 0; k < bicubic_pkg::WIN_N; k++)
         o_win[k] <= {col_pix[k], o_win[k][bicubic_pkg::WIN_N-1:1]};   // newest at col 3
   end

   a_start_idle : assert property (@(posedge i_clk) disable iff (!i_rstn)
      o_sweep_start |-> i_buf_idle);

endmodule

`default_nettype wire

// ==== verilog/bicubic_kernel.sv ====
// three-stage 2x bicubic interpolation of one colour channel
`timescale 1ns/1ps
`default_nettype none

module bicubic_kernel (
   input  wire                                                        i_clk,
   input  wire                                                        i_rstn,
   input  bicubic_pkg::chan_t [bicubic_pkg::WIN_N-1:0][bicubic_pkg::WIN_N-1:0] i_win,
   input  wire                                                        i_valid,
   output bicubic_pkg::chan_t                                         o_p00,
   output bicubic_pkg::chan_t                                         o_p01,
   output bicubic_pkg::chan_t                                         o_p10,
   output bicubic_pkg::chan_t                                         o_p11,
   output logic                                                       o_valid
);

   function automatic bicubic_pkg::acc_t wsum(input bicubic_pkg::acc_t a, input bicubic_pkg::acc_t b,
                                              input bicubic_pkg::acc_t c, input bicubic_pkg::acc_t d);
      return bicubic_pkg::acc_t'(bicubic_pkg::W_OUTER * a + bicubic_pkg::W_INNER * b +
                                 bicubic_pkg::W_INNER * c + bicubic_pkg::W_OUTER * d);
   endfunction

   function automatic bicubic_pkg::chan_t sat(input bicubic_pkg::acc_t v, input int rnd,
                                              input int sh);
      bicubic_pkg::acc_t t;
      t = bicubic_pkg::acc_t'((v + rnd) >>> sh);   // floor
      if (t < 0)
         return '0;
      else if (t > 255)
         return 8'hff;
      return bicubic_pkg::chan_t'(t);
   endfunction

   bicubic_pkg::acc_t  hr  [bicubic_pkg::WIN_N];   // stage 1 row sums
   bicubic_pkg::acc_t  c1  [bicubic_pkg::WIN_N];   // stage 1 column 1
   bicubic_pkg::acc_t  v_col;
   bicubic_pkg::acc_t  v_row;
   bicubic_pkg::acc_t  h1;
   bicubic_pkg::chan_t ctr;
   logic               v1;
   logic               v2;

   always_ff @(posedge i_clk) begin
      for (int k = 0; k < bicubic_pkg::WIN_N; k++) begin
         hr[k] <= wsum(bicubic_pkg::acc_t'(i_win[k][0]), bicubic_pkg::acc_t'(i_win[k][1]),
                       bicubic_pkg::acc_t'(i_win[k][2]), bicubic_pkg::acc_t'(i_win[k][3]));
         c1[k] <= bicubic_pkg::acc_t'(i_win[k][1]);
      end
      // stage 2
      v_col <= wsum(c1[0], c1[1], c1[2], c1[3]);
      v_row <= wsum(hr[0], hr[1], hr[2], hr[3]);
      h1    <= hr[1];
      ctr   <= bicubic_pkg::chan_t'(c1[1]);
      // stage 3
      o_p00 <= ctr;
      o_p01 <= sat(h1, bicubic_pkg::RND_1D, bicubic_pkg::SH_1D);
      o_p10 <= sat(v_col, bicubic_pkg::RND_1D, bicubic_pkg::SH_1D);
      o_p11 <= sat(v_row, bicubic_pkg::RND_2D, bicubic_pkg::SH_2D);
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         v1      <= 1'b0;
         v2      <= 1'b0;
         o_valid <= 1'b0;
      end else begin
         v1      <= i_valid;
         v2      <= v1;
         o_valid <= v2;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/upscale_row_buffer.sv ====
// output row-pair memory, streaming with EOL/EOF
`timescale 1ns/1ps
`default_nettype none

module upscale_row_buffer #(
   parameter int IMG_W = 320,
   parameter int IMG_H = 180
) (
   input  wire                 i_clk,
   input  wire                 i_rstn,
   input  wire                 i_sweep_start,
   input  wire                 i_valid,
   input  bicubic_pkg::pixel_t i_p00,
   input  bicubic_pkg::pixel_t i_p01,
   input  bicubic_pkg::pixel_t i_p10,
   input  bicubic_pkg::pixel_t i_p11,
   output logic                o_idle,
   output bicubic_pkg::pixel_t o_m_data,
   output logic                o_m_valid,
   input  wire                 i_m_ready,
   output logic                o_eol,
   output logic                o_eof
);

   localparam int CW = $clog2(IMG_W);
   localparam int PW = $clog2(2 * IMG_W);
   localparam int HW = $clog2(IMG_H);

   typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_STREAM, ST_DRAIN} state_t;

   state_t        state;
   logic [CW-1:0] wr_x;
   logic [PW-1:0] rd_pos;     // output column 0 .. 2*IMG_W-1
   logic          rd_odd;
   logic [HW-1:0] pair_cnt;
   logic          load;
   logic          last_pos;

   // one entry per window, {2x+1, 2x}
   bicubic_pkg::pixel_t [1:0] even_mem [IMG_W];
   bicubic_pkg::pixel_t [1:0] odd_mem  [IMG_W];
   bicubic_pkg::pixel_t [1:0] rd_pair;

   assign o_idle   = (state == ST_IDLE);
   assign load     = !o_m_valid || i_m_ready;
   assign last_pos = (rd_pos == PW'(2 * IMG_W - 1));
   assign rd_pair  = rd_odd ? odd_mem[rd_pos[PW-1:1]] : even_mem[rd_pos[PW-1:1]];

   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         even_mem[wr_x] <= {i_p01, i_p00};
         odd_mem[wr_x]  <= {i_p11, i_p10};
      end
      if (state == ST_STREAM && load)
         o_m_data <= rd_pair[rd_pos[0]];
   end

   ////////////////////////////////////////
   // fill and stream control
   ////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state     <= ST_IDLE;
         wr_x      <= '0;
         rd_pos    <= '0;
         rd_odd    <= 1'b0;
         pair_cnt  <= '0;
         o_m_valid <= 1'b0;
         o_eol     <= 1'b0;
         o_eof     <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_sweep_start) begin
                  state <= ST_FILL;
                  wr_x  <= '0;
               end
            end
            ST_FILL: begin
               if (i_valid) begin
                  if (wr_x == CW'(IMG_W - 1)) begin
                     state  <= ST_STREAM;   // full row pair stored
                     rd_pos <= '0;
                     rd_odd <= 1'b0;
                  end else begin
                     wr_x <= wr_x + 1'b1;
                  end
               end
            end
            ST_STREAM: begin
               if (load) begin
                  o_m_valid <= 1'b1;
                  o_eol     <= last_pos;
                  o_eof     <= last_pos && rd_odd && (pair_cnt == HW'(IMG_H - 1));
                  if (last_pos) begin
                     rd_pos <= '0;
                     rd_odd <= 1'b1;
                     if (rd_odd)
                        state <= ST_DRAIN;   // last pixel now in the output reg
                  end else begin
                     rd_pos <= rd_pos + 1'b1;
                  end
               end
            end
            ST_DRAIN: begin
               if (i_m_ready) begin
                  o_m_valid <= 1'b0;
                  o_eol     <= 1'b0;
                  o_eof     <= 1'b0;
                  state     <= ST_IDLE;
                  pair_cnt  <= (pair_cnt == HW'(IMG_H - 1)) ? '0 : pair_cnt + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // kernel results only while the row pair is being filled
   a_no_result_busy : assert property (@(posedge i_clk) disable iff (!i_rstn)
      i_valid |-> (state == ST_FILL));

endmodule

`default_nettype wire

// ==== verilog/bicubic_upscaler.sv ====
// top level of the 2x bicubic upscaler, stage wiring and channel split
`timescale 1ns/1ps
`default_nettype none

module bicubic_upscaler #(
   parameter int IMG_W = 320,
   parameter int IMG_H = 180
) (
   input  wire                 i_clk,
   input  wire                 i_rstn,
   input  bicubic_pkg::pixel_t i_s_data,
   input  wire                 i_s_valid,
   output logic                o_s_ready,
   output bicubic_pkg::pixel_t o_m_data,
   output logic                o_m_valid,
   input  wire                 i_m_ready,
   output logic                o_eol,
   output logic                o_eof
);

   localparam int CW   = $clog2(IMG_W);
   localparam int RW   = $clog2(IMG_H + 4);
   localparam int N_CH = bicubic_pkg::PIX_W / bicubic_pkg::CH_W;
   localparam int WN   = bicubic_pkg::WIN_N;

   wire [CW-1:0]                                       rd_col;
   wire [RW-1:0]                                       center_row;
   wire [RW-1:0]                                       rows_done;
   wire                                                frame_done;
   wire                                                sweep_start;
   wire                                                buf_idle;
   wire bicubic_pkg::pixel_t [bicubic_pkg::ROW_SLOTS-1:0] rd_pix;
   wire bicubic_pkg::pixel_t [WN-1:0][WN-1:0]          win;
   wire                                                win_valid;
   wire bicubic_pkg::pixel_t                           p00;
   wire bicubic_pkg::pixel_t                           p01;
   wire bicubic_pkg::pixel_t                           p10;
   wire bicubic_pkg::pixel_t                           p11;
   wire [N_CH-1:0]                                     k_valid;

   line_store #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_line_store (
      .i_clk        (i_clk),
      .i_rstn       (i_rstn),
      .i_s_data     (i_s_data),
      .i_s_valid    (i_s_valid),
      .o_s_ready    (o_s_ready),
      .i_rd_col     (rd_col),
      .o_rd_pix     (rd_pix),
      .i_center_row (center_row),
      .i_frame_done (frame_done),
      .o_rows_done  (rows_done)
   );

   window_sweeper #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_sweeper (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .i_rows_done   (rows_done),
      .i_rd_pix      (rd_pix),
      .i_buf_idle    (buf_idle),
      .o_rd_col      (rd_col),
      .o_center_row  (center_row),
      .o_frame_done  (frame_done),
      .o_sweep_start (sweep_start),
      .o_win         (win),
      .o_win_valid   (win_valid)
   );

   ////////////////////////////////////////
   // one kernel per channel, r in the low byte
   ////////////////////////////////////////
   for (genvar c = 0; c < N_CH; c++) begin : g_ch
      wire bicubic_pkg::chan_t [WN-1:0][WN-1:0] win_ch;

      for (genvar k = 0; k < WN; k++) begin : g_row
         for (genvar j = 0; j < WN; j++) begin : g_col
            assign win_ch[k][j] = win[k][j][c*bicubic_pkg::CH_W +: bicubic_pkg::CH_W];
         end
      end

      bicubic_kernel u_kernel (
         .i_clk   (i_clk),
         .i_rstn  (i_rstn),
         .i_win   (win_ch),
         .i_valid (win_valid),
         .o_p00   (p00[c*bicubic_pkg::CH_W +: bicubic_pkg::CH_W]),
         .o_p01   (p01[c*bicubic_pkg::CH_W +: bicubic_pkg::CH_W]),
         .o_p10   (p10[c*bicubic_pkg::CH_W +: bicubic_pkg::CH_W]),
         .o_p11   (p11[c*bicubic_pkg::CH_W +: bicubic_pkg::CH_W]),
         .o_valid (k_valid[c])
      );
   end

   upscale_row_buffer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_row_buffer (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .i_sweep_start (sweep_start),
      .i_valid       (&k_valid),   // all channels in lockstep
      .i_p00         (p00),
      .i_p01         (p01),
      .i_p10         (p10),
      .i_p11         (p11),
      .o_idle        (buf_idle),
      .o_m_data      (o_m_data),
      .o_m_valid     (o_m_valid),
      .i_m_ready     (i_m_ready),
      .o_eol         (o_eol),
      .o_eof         (o_eof)
   );

endmodule

`default_nettype wire

// ==== bench/tb_bicubic_upscaler.sv ====
// testbench for the 2x bicubic upscaler
// reference model, stalled and back-to-back frames, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_bicubic_upscaler;

   localparam int IMG_W   = 8;
   localparam int IMG_H   = 6;
   localparam int N_FR    = 4;             // random, checker, random stalled x2
   localparam int FR_PIX  = IMG_W * IMG_H;
   localparam int OUT_W   = 2 * IMG_W;
   localparam int OUT_PIX = 4 * FR_PIX;
   localparam int IN_TOT  = N_FR * FR_PIX;
   localparam int OUT_TOT = N_FR * OUT_PIX;
   localparam int WD_NS   = N_FR * 50 * FR_PIX * 100;
   localparam int CW      = bicubic_pkg::CH_W;

   logic                i_clk;
   logic                i_rstn;
   bicubic_pkg::pixel_t i_s_data;
   logic                i_s_valid;
   logic                o_s_ready;
   bicubic_pkg::pixel_t o_m_data;
   logic                o_m_valid;
   logic                i_m_ready;
   logic                o_eol;
   logic                o_eof;

   logic [bicubic_pkg::PIX_W-1:0] frames [IN_TOT];
   logic [bicubic_pkg::PIX_W+1:0] cap_q [$];   // {eof, eol, data}
   integer seed      = 32'h79bf;
   int     in_idx    = 0;
   int     cap_idx   = 0;
   int     err_data  = 0;
   int     err_flag  = 0;
   int     err_hold  = 0;
   int     err_reset = 0;
   int     err_other = 0;
   logic   cmp_done  = 1'b0;

   bicubic_upscaler #(.IMG_W(IMG_W), .IMG_H(IMG_H)) DUT (
      .i_clk     (i_clk),
      .i_rstn    (i_rstn),
      .i_s_data  (i_s_data),
      .i_s_valid (i_s_valid),
      .o_s_ready (o_s_ready),
      .o_m_data  (o_m_data),
      .o_m_valid (o_m_valid),
      .i_m_ready (i_m_ready),
      .o_eol     (o_eol),
      .o_eof     (o_eof)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic int clamp_idx(input int v, input int hi);
      if (v < 0)
         return 0;
      if (v > hi)
         return hi;
      return v;
   endfunction

   function automatic int chan_at(input int f, input int y, input int x, input int c);
      logic [bicubic_pkg::PIX_W-1:0] p;
      p = frames[f * FR_PIX + clamp_idx(y, IMG_H - 1) * IMG_W + clamp_idx(x, IMG_W - 1)];
      return int'(p[c * CW +: CW]);
   endfunction

   function automatic int taps(input int a, input int b, input int c, input int d);
      return 9 * (b + c) - a - d;   // weights -1 9 9 -1
   endfunction

   function automatic int sat8(input int v);
      if (v < 0)
         return 0;
      if (v > 255)
         return 255;
      return v;
   endfunction

   function automatic logic [bicubic_pkg::PIX_W-1:0] ref_pixel(input int f, input int ox,
                                                               input int oy);
      int x;
      int y;
      int v;
      int w [4][4];
      int rs [4];
      logic [bicubic_pkg::PIX_W-1:0] r;
      x = ox / 2;
      y = oy / 2;
      r = '0;
      for (int c = 0; c < 3; c++) begin
         for (int k = 0; k < 4; k++)
            for (int j = 0; j < 4; j++)
               w[k][j] = chan_at(f, y + k - 1, x + j - 1, c);
         for (int k = 0; k < 4; k++)
            rs[k] = taps(w[k][0], w[k][1], w[k][2], w[k][3]);
         if (oy % 2 == 0 && ox % 2 == 0)
            v = w[1][1];                                  // centre
         else if (oy % 2 == 0)
            v = sat8((rs[1] + 8) >>> 4);                  // horizontal half
         else if (ox % 2 == 0)
            v = sat8((taps(w[0][1], w[1][1], w[2][1], w[3][1]) + 8) >>> 4);
         else
            v = sat8((taps(rs[0], rs[1], rs[2], rs[3]) + 128) >>> 8);
         r[c * CW +: CW] = v[7:0];
      end
      return r;
   endfunction

   function automatic logic stall_frame(input int f);
      return f >= 2;   // gaps and back-pressure
   endfunction

   task automatic fill_frames();
      for (int f = 0; f < N_FR; f++)
         for (int y = 0; y < IMG_H; y++)
            for (int x = 0; x < IMG_W; x++)
               if (f == 1)   // 2x2 squares drive the half values past 0 and 255
                  frames[f * FR_PIX + y * IMG_W + x] =
                     ((x / 2 + y / 2) % 2 == 1) ? '1 : '0;
               else
                  frames[f * FR_PIX + y * IMG_W + x] = $random(seed);
   endtask

   task automatic print_counts();
      $display("errors: data %0d, flags %0d, hold %0d, reset %0d, other %0d",
               err_data, err_flag, err_hold, err_reset, err_other);
   endtask

   ////////////////////////////////////////
   // stimulus and capture
   ////////////////////////////////////////
   initial begin
      logic                          sent;
      logic                          held;
      logic [bicubic_pkg::PIX_W+1:0] held_val;
      logic [bicubic_pkg::PIX_W+1:0] now_val;
      sent      = 1'b0;
      held      = 1'b0;
      held_val  = '0;
      i_rstn    = 1'b0;
      i_s_valid = 1'b0;
      i_s_data  = '0;
      i_m_ready = 1'b0;
      fill_frames();
      repeat (5) begin
         @(negedge i_clk);
         if (o_s_ready || o_m_valid) begin
            err_reset++;
            $display("ERR %0t: o_s_ready or o_m_valid high during reset", $time);
         end
      end
      i_rstn = 1'b1;
      @(negedge i_clk);
      if (o_m_valid || o_eol || o_eof) begin
         err_reset++;
         $display("ERR %0t: output valid or flags high right after reset", $time);
      end
      forever begin
         @(negedge i_clk);
         if (sent) begin
            i_s_valid = 1'b0;
            sent      = 1'b0;
         end
         if (!i_s_valid && in_idx < IN_TOT) begin
            if (!(stall_frame(in_idx / FR_PIX) && ($random(seed) & 3) == 0)) begin
               i_s_valid = 1'b1;
               i_s_data  = frames[in_idx];
            end
         end
         if (i_s_valid && o_s_ready) begin   // taken on the coming edge
            sent = 1'b1;
            in_idx++;
         end
         now_val = {o_eof, o_eol, o_m_data};
         if (held && (!o_m_valid || now_val != held_val)) begin
            err_hold++;
            $display("ERR %0t: output changed or dropped while held", $time);
         end
         if (stall_frame(cap_idx / OUT_PIX))
            i_m_ready = ($random(seed) & 3) != 0;
         else
            i_m_ready = 1'b1;
         if (o_m_valid && i_m_ready) begin
            cap_q.push_back(now_val);
            cap_idx++;
         end
         held     = o_m_valid && !i_m_ready;
         held_val = now_val;
      end
   end

   // compare in raster order
   initial begin
      logic [bicubic_pkg::PIX_W+1:0] got;
      logic [bicubic_pkg::PIX_W-1:0] exp_pix;
      logic                          exp_eol;
      logic                          exp_eof;
      int                            f;
      int                            ox;
      int                            oy;
      for (int n = 0; n < OUT_TOT; n++) begin
         while (cap_q.size() == 0)
            @(posedge i_clk);
         got     = cap_q.pop_front();
         f       = n / OUT_PIX;
         oy      = (n % OUT_PIX) / OUT_W;
         ox      = (n % OUT_PIX) % OUT_W;
         exp_pix = ref_pixel(f, ox, oy);
         exp_eol = (ox == OUT_W - 1);
         exp_eof = exp_eol && (oy == 2 * IMG_H - 1);
         if (got[bicubic_pkg::PIX_W-1:0] != exp_pix) begin
            err_data++;
            $display("ERR %0t: frame %0d (%0d,%0d) data %h expected %h", $time, f, ox, oy,
                     got[bicubic_pkg::PIX_W-1:0], exp_pix);
         end
         if (got[bicubic_pkg::PIX_W] != exp_eol || got[bicubic_pkg::PIX_W+1] != exp_eof) begin
            err_flag++;
            $display("ERR %0t: frame %0d (%0d,%0d) eol/eof %b%b expected %b%b", $time, f, ox,
                     oy, got[bicubic_pkg::PIX_W], got[bicubic_pkg::PIX_W+1], exp_eol, exp_eof);
         end
      end
      cmp_done = 1'b1;
   end

   initial begin
      while (!cmp_done)
         @(posedge i_clk);
      repeat (20) @(posedge i_clk);   // catch trailing extra outputs
      if (cap_q.size() != 0) begin
         err_other++;
         $display("%0d output pixels arrived after the last frame", cap_q.size());
      end
      if (in_idx != IN_TOT) begin
         err_other++;
         $display("only %0d of %0d input pixels were accepted", in_idx, IN_TOT);
      end
      print_counts();
      if (err_data + err_flag + err_hold + err_reset + err_other == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // watchdog
   initial begin
      #(WD_NS);
      $display("timeout with %0d of %0d output pixels received", cap_idx, OUT_TOT);
      print_counts();
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bicubic_upscaler.f ====
verilog/bicubic_pkg.sv
verilog/line_store.sv
verilog/window_sweeper.sv
verilog/bicubic_kernel.sv
verilog/upscale_row_buffer.sv
verilog/bicubic_upscaler.sv
bench/tb_bicubic_upscaler.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with Verilator and run it
# exit status 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f bicubic_upscaler.f \
   --top-module tb_bicubic_upscaler \
   -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1
